//--- sim.f
verilog/sd_pkg.sv
verilog/selftest_pkg.sv
verilog/sd_block_if.sv
verilog/sd_spi_shifter.sv
verilog/sd_block_engine.sv
verilog/sd_block_checker.sv
verilog/sd_selftest_top.sv
tb/sd_card_model.sv
tb/tb_sd_selftest.sv

//--- Makefile
# Verilator build, run, lint and clean for the sd self-test
TOP = tb_sd_selftest

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- tb/tb_sd_selftest.sv
// testbench running the sd self-test once clean and once with a corrupted read
`timescale 1ns/1ps
`default_nettype none

module tb_sd_selftest;

  localparam int     RESET_CYCLES = 16;
  localparam int     NUM_BLOCKS   = selftest_pkg::NUM_BLOCKS;
  localparam int     BLOCK_BYTES  = sd_pkg::BLOCK_BYTES;
  localparam int     TRANSFERS    = 2 * NUM_BLOCKS;
  localparam int     BAD_READ     = NUM_BLOCKS + 2;  // read of block 2
  localparam longint WATCHDOG_NS  = 64'd2 * TRANSFERS * 540 * 32 * 4 * 2;

  logic clock = 1'b0;
  logic reset;
  logic corrupt_read;
  logic sclk;
  logic mosi;
  logic miso;
  logic cs_n;
  logic test_done;
  logic test_error;
  int   cmds_seen   = 0;
  int   phase_first = 0;  // command count when the phase began

  always #2 clock = ~clock;

  sd_selftest_top u_sd_selftest_top (
    .clock      (clock),
    .reset      (reset),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso),
    .cs_n       (cs_n),
    .test_done  (test_done),
    .test_error (test_error)
  );

  sd_card_model u_card (
    .sclk         (sclk),
    .mosi         (mosi),
    .miso         (miso),
    .cs_n         (cs_n),
    .corrupt_read (corrupt_read)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic sd_pkg::sd_byte_t pattern_byte(input int blk, input int idx);
    return sd_pkg::sd_byte_t'(idx + selftest_pkg::PATTERN_STEP * blk) ^
           selftest_pkg::PATTERN_MASK;
  endfunction

  assert property (@(posedge clock) reset |=> (cs_n && !sclk && !test_done && !test_error))
    else stop_on_error("outputs left their reset values around reset release");

  assert property (@(posedge clock) disable iff (reset) sclk |-> !cs_n)
    else stop_on_error("sclk toggled while cs_n was high");

  assert property (@(posedge clock) disable iff (reset) !cs_n |-> !(test_done || test_error))
    else stop_on_error("a test result showed up during a card transfer");

  task automatic check_memory();
    sd_pkg::sd_byte_t exp;
    for (int a = 0; a < NUM_BLOCKS; a++) begin
      for (int i = 0; i < BLOCK_BYTES; i++) begin
        exp = pattern_byte(a, i);
        assert (u_card.mem[a * BLOCK_BYTES + i] == exp)
          else stop_on_error($sformatf("MISMATCH mem[%0d] expected 0x%02h actual 0x%02h",
                                       a * BLOCK_BYTES + i, exp, u_card.mem[a * BLOCK_BYTES + i]));
      end
    end
  endtask

  task automatic check_command(input int idx);
    sd_pkg::sd_byte_t exp_cmd;
    sd_pkg::sd_addr_t exp_addr;
    exp_cmd  = (idx < NUM_BLOCKS) ? (8'h40 | 8'd24) : (8'h40 | 8'd17);
    exp_addr = sd_pkg::sd_addr_t'(idx % NUM_BLOCKS);
    assert ((idx < TRANSFERS) && !(corrupt_read && (idx > BAD_READ)))
      else stop_on_error($sformatf("card saw an unexpected extra command, number %0d", idx));
    assert (u_card.last_cmd == exp_cmd)
      else stop_on_error($sformatf("MISMATCH last_cmd expected 0x%02h actual 0x%02h",
                                   exp_cmd, u_card.last_cmd));
    assert (u_card.last_addr == exp_addr)
      else stop_on_error($sformatf("MISMATCH last_addr expected 0x%08h actual 0x%08h",
                                   exp_addr, u_card.last_addr));
    assert (u_card.last_crc == 8'hFF)
      else stop_on_error($sformatf("MISMATCH last_crc expected 0xff actual 0x%02h",
                                   u_card.last_crc));
    if (idx == NUM_BLOCKS) begin
      check_memory();  // all four writes are in by the first read
    end
  endtask

  always @(negedge clock) begin
    if (u_card.cmd_count != cmds_seen) begin
      check_command(cmds_seen - phase_first);
      cmds_seen = cmds_seen + 1;
    end
  end

  task automatic run_phase(input logic corrupt);
    @(posedge clock);
    reset        <= 1'b1;
    corrupt_read <= corrupt;
    phase_first  = cmds_seen;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    do begin
      @(negedge clock);
    end while (!(test_done || test_error));
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("timeout, the self-test never reported a result");
  end

  initial begin
    reset        = 1'b1;
    corrupt_read = 1'b0;
    run_phase(1'b0);
    assert (test_done && !test_error)
      else stop_on_error($sformatf("MISMATCH test_done,test_error expected 1,0 actual %h,%h",
                                   test_done, test_error));
    run_phase(1'b1);  // block 2 comes back with one flipped bit
    assert (test_error && !test_done)
      else stop_on_error($sformatf("MISMATCH test_done,test_error expected 0,1 actual %h,%h",
                                   test_done, test_error));
    if (cmds_seen - phase_first == BAD_READ + 1) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("MISMATCH cmd_count expected 0x%0h actual 0x%0h",
                              BAD_READ + 1, cmds_seen - phase_first));
    end
  end

endmodule

`default_nettype wire

//--- tb/sd_card_model.sv
// behavioral spi-mode sd card answering single-block read and write commands
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  input  logic cs_n,
  input  logic corrupt_read
);

  localparam int MEM_BYTES = selftest_pkg::NUM_BLOCKS * sd_pkg::BLOCK_BYTES;

  typedef enum {CARD_CMD, CARD_TOKEN, CARD_DATA, CARD_CRC, CARD_HOLD} card_state_t;

  sd_pkg::sd_byte_t mem [MEM_BYTES];
  sd_pkg::sd_byte_t resp_q [$];  // bytes queued for miso
  sd_pkg::sd_byte_t frame [6];
  sd_pkg::sd_byte_t rx_sr;
  sd_pkg::sd_byte_t tx_sr   = 8'hFF;
  sd_pkg::sd_byte_t next_tx = 8'hFF;
  card_state_t      state;
  int               bit_cnt;
  int               byte_cnt;
  int               blk_idx;

  // last command frame, watched by the testbench
  int               cmd_count = 0;
  sd_pkg::sd_byte_t last_cmd;
  sd_pkg::sd_addr_t last_addr;
  sd_pkg::sd_byte_t last_crc;

  assign miso = cs_n ? 1'b1 : tx_sr[7];

  task automatic queue_read(input int blk);
    sd_pkg::sd_byte_t data;
    resp_q.push_back(8'hFF);  // two idle bytes before the token
    resp_q.push_back(8'hFF);
    resp_q.push_back(8'hFE);
    for (int i = 0; i < sd_pkg::BLOCK_BYTES; i++) begin
      data = mem[blk * sd_pkg::BLOCK_BYTES + i];
      if (corrupt_read && (blk == 2) && (i == 100)) begin
        data = data ^ 8'h01;
      end
      resp_q.push_back(data);
    end
    resp_q.push_back(8'hFF);  // crc, never checked
    resp_q.push_back(8'hFF);
  endtask

  task automatic take_byte(input sd_pkg::sd_byte_t rx);
    case (state)
      CARD_CMD: begin
        frame[byte_cnt] = rx;
        byte_cnt++;
        if (byte_cnt == 6) begin
          byte_cnt  = 0;
          last_cmd  = frame[0];
          last_addr = {frame[1], frame[2], frame[3], frame[4]};
          last_crc  = frame[5];
          blk_idx   = int'(last_addr % selftest_pkg::NUM_BLOCKS);
          cmd_count++;
          resp_q.push_back(8'hFF);  // r1 after one idle byte
          resp_q.push_back(8'h00);
          if (last_cmd == 8'h58) begin
            state = CARD_TOKEN;
          end else begin
            queue_read(blk_idx);
            state = CARD_HOLD;
          end
        end
      end
      CARD_TOKEN: begin
        if (rx == 8'hFE) state = CARD_DATA;
      end
      CARD_DATA: begin
        mem[blk_idx * sd_pkg::BLOCK_BYTES + byte_cnt] = rx;
        byte_cnt++;
        if (byte_cnt == sd_pkg::BLOCK_BYTES) begin
          byte_cnt = 0;
          state    = CARD_CRC;
        end
      end
      CARD_CRC: begin
        byte_cnt++;
        if (byte_cnt == 2) begin
          resp_q.push_back(8'h05);  // data accepted
          resp_q.push_back(8'h00);  // then three busy bytes
          resp_q.push_back(8'h00);
          resp_q.push_back(8'h00);
          state = CARD_HOLD;
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'hFF;  // erased card
    end
    state    = CARD_CMD;
    bit_cnt  = 0;
    byte_cnt = 0;
    forever begin
      @(posedge sclk or posedge cs_n);
      if (cs_n) begin
        state    = CARD_CMD;  // new frame on next select
        bit_cnt  = 0;
        byte_cnt = 0;
        next_tx  = 8'hFF;
        resp_q.delete();
      end else begin
        rx_sr = {rx_sr[6:0], mosi};
        bit_cnt++;
        if (bit_cnt == 8) begin
          bit_cnt = 0;
          take_byte(rx_sr);
          next_tx = (resp_q.size() != 0) ? resp_q.pop_front() : 8'hFF;
        end
      end
    end
  end

  // miso changes on falling sclk
  always @(negedge sclk or posedge cs_n) begin
    if (cs_n) begin
      tx_sr <= 8'hFF;
    end else if (bit_cnt == 0) begin
      tx_sr <= next_tx;
    end else begin
      tx_sr <= {tx_sr[6:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

//--- verilog/sd_selftest_top.sv
// sd card self-test top joining checker, block engine and spi shifter
`timescale 1ns/1ps
`default_nettype none

module sd_selftest_top (
  input  logic clock,
  input  logic reset,
  output logic sclk,
  output logic mosi,
  input  logic miso,
  output logic cs_n,
  output logic test_done,
  output logic test_error
);

  logic             start;
  sd_pkg::sd_byte_t tx_byte;
  logic             select;
  sd_pkg::sd_byte_t rx_byte;
  logic             done;

  sd_block_if blk_if ();

  sd_block_checker u_checker (
    .clock      (clock),
    .reset      (reset),
    .blk        (blk_if.requester),
    .test_done  (test_done),
    .test_error (test_error)
  );

  sd_block_engine u_engine (
    .clock   (clock),
    .reset   (reset),
    .blk     (blk_if.server),
    .start   (start),
    .tx_byte (tx_byte),
    .select  (select),
    .rx_byte (rx_byte),
    .done    (done)
  );

  sd_spi_shifter u_shifter (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .tx_byte (tx_byte),
    .select  (select),
    .rx_byte (rx_byte),
    .done    (done),
    .sclk    (sclk),
    .mosi    (mosi),
    .miso    (miso),
    .cs_n    (cs_n)
  );

endmodule

`default_nettype wire

//--- verilog/sd_block_checker.sv
// self-test sequencer writing four pattern blocks and verifying each on read-back
`timescale 1ns/1ps
`default_nettype none

module sd_block_checker (
  input  logic          clock,
  input  logic          reset,
  sd_block_if.requester blk,
  output logic          test_done,
  output logic          test_error
);

  selftest_pkg::checker_state_t state;
  selftest_pkg::block_idx_t     blk_idx;
  sd_pkg::sd_block_t            expected;
  logic                         last_blk;

  assign last_blk = (blk_idx == selftest_pkg::block_idx_t'(selftest_pkg::NUM_BLOCKS - 1));

  // pattern regenerated from the block index
  always_comb begin
    for (int i = 0; i < sd_pkg::BLOCK_BYTES; i++) begin
      expected[(sd_pkg::BLOCK_BYTES - 1 - i) * 8 +: 8] =
        sd_pkg::sd_byte_t'(i + selftest_pkg::PATTERN_STEP * int'(blk_idx)) ^
        selftest_pkg::PATTERN_MASK;
    end
  end

  assign blk.wr_en      = (state == selftest_pkg::WRITE_REQ);
  assign blk.rd_en      = (state == selftest_pkg::READ_REQ);
  assign blk.addr       = sd_pkg::sd_addr_t'(blk_idx);
  assign blk.write_data = expected;

  assign test_done  = (state == selftest_pkg::DONE);
  assign test_error = (state == selftest_pkg::FAIL);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= selftest_pkg::WRITE_REQ;
      blk_idx <= '0;
    end else begin
      case (state)
        selftest_pkg::WRITE_REQ: begin
          if (blk.busy) state <= selftest_pkg::WRITE_WAIT;
        end
        selftest_pkg::WRITE_WAIT: begin
          if (!blk.busy) begin
            blk_idx <= last_blk ? '0 : blk_idx + 1'b1;
            state   <= last_blk ? selftest_pkg::READ_REQ : selftest_pkg::WRITE_REQ;
          end
        end
        selftest_pkg::READ_REQ: begin
          if (blk.busy) state <= selftest_pkg::READ_WAIT;
        end
        selftest_pkg::READ_WAIT: begin
          if (!blk.busy) state <= selftest_pkg::COMPARE;
        end
        selftest_pkg::COMPARE: begin
          if (blk.read_data != expected) begin
            state <= selftest_pkg::FAIL;
          end else if (last_blk) begin
            state <= selftest_pkg::DONE;
          end else begin
            blk_idx <= blk_idx + 1'b1;
            state   <= selftest_pkg::READ_REQ;
          end
        end
        selftest_pkg::DONE: state <= selftest_pkg::DONE;  // held until reset
        selftest_pkg::FAIL: state <= selftest_pkg::FAIL;
        default: state <= selftest_pkg::WRITE_REQ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/sd_block_engine.sv
// single-block read and write engine issuing cmd17 and cmd24 over the byte shifter
`timescale 1ns/1ps
`default_nettype none

module sd_block_engine (
  input  logic             clock,
  input  logic             reset,
  sd_block_if.server       blk,
  output logic             start,
  output sd_pkg::sd_byte_t tx_byte,
  output logic             select,
  input  sd_pkg::sd_byte_t rx_byte,
  input  logic             done
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_CMD,
    ST_R1,
    ST_GAP,
    ST_TOKEN,
    ST_WDATA,
    ST_WCRC,
    ST_DRESP,
    ST_WBUSY,
    ST_RTOKEN,
    ST_RDATA,
    ST_RCRC
  } engine_state_t;

  engine_state_t     state;
  logic              pending;
  logic              is_write;
  sd_pkg::sd_index_t cnt;
  sd_pkg::sd_addr_t  addr_q;
  sd_pkg::sd_block_t blk_q;
  sd_pkg::sd_block_t rdata_q;
  logic              accept;
  logic              step;
  logic              last_cmd;
  logic              last_byte;
  logic              data_ok;
  logic              finish;

  assign accept    = (state == ST_IDLE) && (blk.rd_en || blk.wr_en);
  assign step      = pending && done;
  assign start     = (state != ST_IDLE) && !pending;  // one byte per step
  assign last_cmd  = (cnt == sd_pkg::sd_index_t'(sd_pkg::CMD_BYTES - 1));
  assign last_byte = (cnt == sd_pkg::sd_index_t'(sd_pkg::BLOCK_BYTES - 1));
  assign data_ok   = ((rx_byte & sd_pkg::DATA_RESP_MASK) == sd_pkg::DATA_ACCEPTED);

  // a rejected write has no busy phase to wait out
  assign finish = step && (((state == ST_DRESP) && !data_ok) ||
                           ((state == ST_WBUSY) && (rx_byte != 8'h00)) ||
                           ((state == ST_RCRC) && cnt[0]));

  always_comb begin
    case (state)
      ST_CMD: begin
        if (cnt == '0) tx_byte = is_write ? sd_pkg::CMD_WRITE_BLOCK : sd_pkg::CMD_READ_BLOCK;
        else if (last_cmd) tx_byte = sd_pkg::CRC_DUMMY;
        else tx_byte = addr_q[31:24];  // msb first
      end
      ST_TOKEN: tx_byte = sd_pkg::START_TOKEN;
      ST_WDATA: tx_byte = blk_q[4095:4088];
      ST_WCRC:  tx_byte = sd_pkg::CRC_DUMMY;
      default:  tx_byte = sd_pkg::IDLE_BYTE;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      pending  <= 1'b0;
      is_write <= 1'b0;
      cnt      <= '0;
      select   <= 1'b0;
      blk.busy <= 1'b0;
    end else begin
      if (start) pending <= 1'b1;
      else if (done) pending <= 1'b0;

      if (accept) begin
        state    <= ST_CMD;
        cnt      <= '0;
        is_write <= blk.wr_en;
        select   <= 1'b1;
        blk.busy <= 1'b1;
      end else if (finish) begin
        state    <= ST_IDLE;
        select   <= 1'b0;
        blk.busy <= 1'b0;
      end else if (step) begin
        case (state)
          ST_CMD: begin
            cnt <= last_cmd ? '0 : cnt + 1'b1;
            if (last_cmd) state <= ST_R1;
          end
          ST_R1: begin
            if (rx_byte != sd_pkg::IDLE_BYTE) state <= is_write ? ST_GAP : ST_RTOKEN;
          end
          ST_GAP:   state <= ST_TOKEN;
          ST_TOKEN: state <= ST_WDATA;
          ST_WDATA: begin
            cnt <= last_byte ? '0 : cnt + 1'b1;
            if (last_byte) state <= ST_WCRC;
          end
          ST_WCRC: begin
            cnt <= cnt[0] ? '0 : cnt + 1'b1;  // two crc bytes
            if (cnt[0]) state <= ST_DRESP;
          end
          ST_DRESP: state <= ST_WBUSY;
          ST_WBUSY: state <= ST_WBUSY;  // card holds 0x00 while programming
          ST_RTOKEN: begin
            if (rx_byte == sd_pkg::START_TOKEN) state <= ST_RDATA;
          end
          ST_RDATA: begin
            cnt <= last_byte ? '0 : cnt + 1'b1;
            if (last_byte) state <= ST_RCRC;
          end
          ST_RCRC: cnt <= cnt + 1'b1;
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // one shift register moves data out on writes and in on reads
  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= blk.addr;
      blk_q  <= blk.write_data;
    end else if (step) begin
      if ((state == ST_CMD) && (cnt != '0)) addr_q <= {addr_q[23:0], 8'h00};
      if ((state == ST_WDATA) || (state == ST_RDATA)) blk_q <= {blk_q[4087:0], rx_byte};
      if (finish && !is_write) rdata_q <= blk_q;
    end
  end

  assign blk.read_data = rdata_q;

endmodule

`default_nettype wire

//--- verilog/sd_spi_shifter.sv
// spi mode-0 byte transceiver with sclk divider and registered chip select
`timescale 1ns/1ps
`default_nettype none

module sd_spi_shifter (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  sd_pkg::sd_byte_t tx_byte,
  input  logic             select,
  output sd_pkg::sd_byte_t rx_byte,
  output logic             done,
  output logic             sclk,
  output logic             mosi,
  input  logic             miso,
  output logic             cs_n
);

  logic             active;
  sd_pkg::spi_div_t div_cnt;
  logic [2:0]       bit_cnt;
  logic             half_tick;
  logic             miso_q;
  sd_pkg::sd_byte_t shift_q;

  assign half_tick = active && (div_cnt == sd_pkg::spi_div_t'(sd_pkg::SPI_HALF_PERIOD - 1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      active  <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      done    <= 1'b0;
      cs_n    <= 1'b1;
    end else begin
      done <= 1'b0;
      cs_n <= ~select;
      if (start && !active) begin
        active  <= 1'b1;
        div_cnt <= sd_pkg::spi_div_t'(1);  // start cycle counts toward the first half
        bit_cnt <= '0;
        sclk    <= 1'b0;
      end else if (half_tick) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (sclk) begin  // falling edge
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            active <= 1'b0;
            done   <= 1'b1;
          end
        end
      end else if (active) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start && !active) begin
      shift_q <= tx_byte;
    end else if (half_tick) begin
      if (!sclk) miso_q <= miso;  // sample on rising sclk
      else shift_q <= {shift_q[6:0], miso_q};
    end
  end

  assign mosi    = active ? shift_q[7] : 1'b1;  // line idles high
  assign rx_byte = shift_q;

endmodule

`default_nettype wire

//--- verilog/sd_block_if.sv
// block request bus between the self-test checker and the block engine
`timescale 1ns/1ps
`default_nettype none

interface sd_block_if;

  logic              rd_en;
  logic              wr_en;
  sd_pkg::sd_addr_t  addr;
  sd_pkg::sd_block_t write_data;
  sd_pkg::sd_block_t read_data;
  logic              busy;

  modport requester (
    output rd_en, wr_en, addr, write_data,
    input  read_data, busy
  );

  modport server (
    input  rd_en, wr_en, addr, write_data,
    output read_data, busy
  );

endinterface

`default_nettype wire

//--- verilog/selftest_pkg.sv
// self-test package with checker states, block count and data pattern rule
`default_nettype none

package selftest_pkg;

  typedef enum logic [2:0] {
    WRITE_REQ,
    WRITE_WAIT,
    READ_REQ,
    READ_WAIT,
    COMPARE,
    DONE,
    FAIL
  } checker_state_t;

  localparam int NUM_BLOCKS   = 4;
  localparam int PATTERN_STEP = 37;  // per-block offset of the byte ramp

  localparam sd_pkg::sd_byte_t PATTERN_MASK = 8'h5A;

  typedef logic [$clog2(NUM_BLOCKS)-1:0] block_idx_t;

endpackage

`default_nettype wire

//--- verilog/sd_pkg.sv
// sd spi-mode package with protocol byte values, bus timing and block types
`default_nettype none

package sd_pkg;

  localparam int BLOCK_BYTES     = 512;
  localparam int CMD_BYTES       = 6;  // command, 4 address bytes, crc
  localparam int SPI_HALF_PERIOD = 2;  // system clocks per sclk half period
  localparam int SPI_DIV_W       = $clog2(SPI_HALF_PERIOD + 1);

  typedef logic [7:0]                   sd_byte_t;
  typedef logic [BLOCK_BYTES*8-1:0]     sd_block_t;  // byte 0 in the top bits
  typedef logic [31:0]                  sd_addr_t;
  typedef logic [$clog2(BLOCK_BYTES)-1:0] sd_index_t;
  typedef logic [SPI_DIV_W-1:0]         spi_div_t;

  localparam sd_byte_t CMD_READ_BLOCK  = 8'h51;  // cmd17 with start bits
  localparam sd_byte_t CMD_WRITE_BLOCK = 8'h58;  // cmd24
  localparam sd_byte_t CRC_DUMMY       = 8'hFF;
  localparam sd_byte_t START_TOKEN     = 8'hFE;
  localparam sd_byte_t IDLE_BYTE       = 8'hFF;
  localparam sd_byte_t DATA_ACCEPTED   = 8'h05;
  localparam sd_byte_t DATA_RESP_MASK  = 8'h1F;  // status bits of the data response

endpackage

`default_nettype wire
